// File: build.f
+incdir+verilog
+incdir+tb
verilog/vctrl_pkg.sv
verilog/vctrl_csr_if.sv
verilog/vctrl_csr_file.sv
verilog/vctrl_issue.sv
verilog/vctrl_result.sv
verilog/vctrl_top.sv
tb/tb_vctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_vctrl -Mdir obj_dir

output=$(./obj_dir/Vtb_vctrl)
echo "$output"

if echo "$output" | grep -qx "NO ERRORS"; then
  exit 0
else
  exit 1
fi

// File: tb/tb_vctrl_cases.svh
/*
 * Stimulus table with expected values, its driving loop
 * and the directed sequences for ID exhaustion and result priority
 */

`ifndef TB_VCTRL_CASES_SVH
`define TB_VCTRL_CASES_SVH

// exp_v is the result data for CSR ops and the request vl for VARITH
typedef struct {
  op_e        op;
  logic[31:0] rs1;
  vsew_e      vsew;
  vlmul_e     vlmul;
  csr_mode_e  mode;
  csr_addr_e  addr;
  logic       widen;
  logic       accept;
  logic[31:0] exp_v;
  logic[1:0]  exp_id;
} row_t;

row_t rows[$];

// vtype {vill 0, EW_16, LMUL_1} and vstart left by the table
localparam logic [6:0] ARITH_VTYPE  = 7'h08;
localparam logic [8:0] ARITH_VSTART = 9'd3;

task automatic add_row(input op_e op, input logic [31:0] rs1, input vsew_e vsew,
                       input vlmul_e vlmul, input csr_mode_e mode, input csr_addr_e addr,
                       input logic widen, input logic accept, input logic [31:0] exp_v,
                       input logic [1:0] exp_id);
  rows.push_back('{op, rs1, vsew, vlmul, mode, addr, widen, accept, exp_v, exp_id});
endtask

task automatic build_table();
  add_row(VCFG,   32'd100,      EW_32, LMUL_2,  CSR_READ,  CSR_VL,     0, 1, 32'd16,  0);
  add_row(VCFG,   32'hffffffff, EW_8,  LMUL_8,  CSR_READ,  CSR_VL,     0, 1, 32'd256, 0);
  add_row(VCFG,   32'd100,      EW_8,  LMUL_F2, CSR_READ,  CSR_VL,     0, 1, 32'd16,  0);
  add_row(VCFG,   32'd100,      EW_64, LMUL_1,  CSR_READ,  CSR_VL,     0, 1, 32'd0,   0);
  add_row(VCSR,   32'd0,        EW_8,  LMUL_1,  CSR_READ,  CSR_VTYPE,  0, 1, 32'h80000000, 0);
  add_row(VARITH, 32'd0,        EW_8,  LMUL_1,  CSR_READ,  CSR_VL,     0, 0, 32'd0,   0);
  add_row(VCFG,   32'd100,      EW_16, LMUL_F8, CSR_READ,  CSR_VL,     0, 1, 32'd0,   0);
  add_row(VCFG,   32'd5,        EW_16, LMUL_1,  CSR_READ,  CSR_VL,     0, 1, 32'd5,   0);
  add_row(VCSR,   32'h0a5,      EW_8,  LMUL_1,  CSR_WRITE, CSR_VSTART, 0, 1, 32'd0,   0);
  add_row(VCSR,   32'd0,        EW_8,  LMUL_1,  CSR_READ,  CSR_VSTART, 0, 1, 32'h0a5, 0);
  add_row(VCSR,   32'h10a,      EW_8,  LMUL_1,  CSR_SET,   CSR_VSTART, 0, 1, 32'h0a5, 0);
  add_row(VCSR,   32'h00f,      EW_8,  LMUL_1,  CSR_CLEAR, CSR_VSTART, 0, 1, 32'h1af, 0);
  add_row(VCSR,   32'd0,        EW_8,  LMUL_1,  CSR_READ,  CSR_VSTART, 0, 1, 32'h1a0, 0);
  add_row(VCSR,   32'd0,        EW_8,  LMUL_1,  CSR_READ,  CSR_VLENB,  0, 1, 32'd32,  0);
  add_row(VCSR,   32'd0,        EW_8,  LMUL_1,  CSR_READ,  CSR_VL,     0, 1, 32'd5,   0);
  add_row(VCSR,   32'd3,        EW_8,  LMUL_1,  CSR_WRITE, CSR_VSTART, 0, 1, 32'h1a0, 0);
  add_row(VARITH, 32'd0,        EW_8,  LMUL_1,  CSR_READ,  CSR_VL,     0, 1, 32'd5,   0);
  add_row(VARITH, 32'd0,        EW_8,  LMUL_1,  CSR_READ,  CSR_VL,     1, 1, 32'd10,  1);
  add_row(VARITH, 32'd0,        EW_8,  LMUL_1,  CSR_READ,  CSR_VL,     0, 1, 32'd5,   2);
  add_row(VARITH, 32'd0,        EW_8,  LMUL_1,  CSR_READ,  CSR_VL,     0, 1, 32'd5,   3);
endtask

// Holds the instruction until issue_ready_o, returns the accept answer
task automatic send_insn(input op_e op, input logic [31:0] rs1, input vsew_e vsew,
                         input vlmul_e vlmul, input csr_mode_e mode, input csr_addr_e addr,
                         input logic [4:0] tag, input logic widen, output logic accepted);
  issue_valid_i    = 1'b1;
  issue_op_i       = op;
  issue_rs1_i      = rs1;
  issue_vtype_i    = '{vill: 1'b0, vsew: vsew, vlmul: vlmul};
  issue_csr_mode_i = mode;
  issue_csr_addr_i = addr;
  issue_rd_i       = tag;
  issue_vd_i       = tag;
  issue_widen_i    = widen;
  @(negedge clk_i);
  while (!issue_ready_o) @(negedge clk_i);
  accepted = issue_accept_o;
  @(posedge clk_i);
  #1;
  issue_valid_i = 1'b0;
endtask

task automatic wait_result(input logic [4:0] rd, input logic [31:0] data);
  @(negedge clk_i);
  while (!(result_valid_o && result_ready_i)) @(negedge clk_i);
  compare_value("result_rd_o", 32'(result_rd_o), 32'(rd));
  compare_value("result_data_o", result_data_o, data);
  @(posedge clk_i);
  #1;
endtask

// Ready toggles at random until the request transfers
task automatic wait_request(input logic [1:0] id, input logic [4:0] vd, input logic [8:0] vl);
  while (1) begin
    unit_req_ready_i = 1'($random(seed));
    @(negedge clk_i);
    if (unit_req_valid_o && unit_req_ready_i) break;
    @(posedge clk_i);
    #1;
  end
  compare_value("unit_req_o.id", 32'(unit_req_o.id), 32'(id));
  compare_value("unit_req_o.vd", 32'(unit_req_o.vd), 32'(vd));
  compare_value("unit_req_o.vl", 32'(unit_req_o.vl), 32'(vl));
  compare_value("unit_req_o.vtype", 32'(unit_req_o.vtype), 32'(ARITH_VTYPE));
  compare_value("unit_req_o.vstart", 32'(unit_req_o.vstart), 32'(ARITH_VSTART));
  @(posedge clk_i);
  #1;
  unit_req_ready_i = 1'b0;
endtask

task automatic respond(input logic [1:0] id, input logic wb, input logic [4:0] rd,
                       input logic [31:0] data);
  unit_rsp_valid_i = 1'b1;
  unit_rsp_id_i    = id;
  unit_rsp_wb_i    = wb;
  unit_rsp_rd_i    = rd;
  unit_rsp_data_i  = data;
  @(negedge clk_i);
  while (wb && !unit_rsp_ready_o) @(negedge clk_i);
  @(posedge clk_i);
  #1;
  unit_rsp_valid_i = 1'b0;
endtask

task automatic run_table();
  logic acc;
  foreach (rows[i]) begin
    send_insn(rows[i].op, rows[i].rs1, rows[i].vsew, rows[i].vlmul, rows[i].mode,
              rows[i].addr, 5'(i), rows[i].widen, acc);
    compare_value("issue_accept_o", 32'(acc), 32'(rows[i].accept));
    if (acc && rows[i].op == VARITH) begin
      wait_request(rows[i].exp_id, 5'(i), rows[i].exp_v[8:0]);
    end else if (acc) begin
      wait_result(5'(i), rows[i].exp_v);
    end
  end
endtask

task automatic run_directed();
  logic acc;
  // All four IDs running, a fifth VARITH fills the buffer
  send_insn(VARITH, 0, EW_8, LMUL_1, CSR_READ, CSR_VL, 5'd21, 1'b0, acc);
  compare_value("issue_accept_o", 32'(acc), 32'd1);
  repeat (10) begin
    @(negedge clk_i);
    compare_value("issue_ready_o", 32'(issue_ready_o), 32'd0);
    compare_value("unit_req_valid_o", 32'(unit_req_valid_o), 32'd0);
    compare_value("busy_o", 32'(busy_o), 32'd1);
  end
  @(posedge clk_i);
  #1;
  respond(2'd1, 1'b1, 5'd7, 32'hdeadbeef);
  wait_result(5'd7, 32'hdeadbeef);
  wait_request(2'd1, 5'd21, 9'd5);
  respond(2'd0, 1'b0, 5'd0, 32'd0);
  respond(2'd1, 1'b0, 5'd0, 32'd0);
  respond(2'd2, 1'b0, 5'd0, 32'd0);
  respond(2'd3, 1'b0, 5'd0, 32'd0);
  @(negedge clk_i);
  compare_value("busy_o", 32'(busy_o), 32'd0);
  @(posedge clk_i);
  #1;
  // CSR and unit results competing for the result register
  send_insn(VARITH, 0, EW_8, LMUL_1, CSR_READ, CSR_VL, 5'd22, 1'b0, acc);
  wait_request(2'd0, 5'd22, 9'd5);
  result_ready_i = 1'b0;
  send_insn(VCSR, 0, EW_8, LMUL_1, CSR_READ, CSR_VL, 5'd10, 1'b0, acc);
  send_insn(VCSR, 0, EW_8, LMUL_1, CSR_READ, CSR_VLENB, 5'd11, 1'b0, acc);
  result_ready_i = 1'b1;
  fork
    respond(2'd0, 1'b1, 5'd12, 32'h00001234);
    begin
      wait_result(5'd10, 32'd5);
      wait_result(5'd11, 32'd32);
      wait_result(5'd12, 32'h00001234);
    end
  join
  @(negedge clk_i);
  compare_value("busy_o", 32'(busy_o), 32'd0);
endtask

`endif

// File: tb/tb_vctrl.sv
/*
 * Testbench for the vector-unit controller
 * Clock, reset, DUT, watchdog, result checker and the closing report
 */

`default_nettype none

`include "vctrl_consts.svh"

module tb_vctrl
  import vctrl_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NR_STEPS    = 45;
  localparam int WATCHDOG_NS = NR_STEPS * 200 * 8;

  logic                     clk_i;
  logic                     arst_n_i;
  logic                     issue_valid_i;
  logic                     issue_ready_o;
  logic                     issue_accept_o;
  op_e                      issue_op_i;
  logic [`VCTRL_RD_W-1:0]   issue_rd_i;
  logic [`VCTRL_ELEN-1:0]   issue_rs1_i;
  vtype_t                   issue_vtype_i;
  csr_mode_e                issue_csr_mode_i;
  csr_addr_e                issue_csr_addr_i;
  logic [`VCTRL_VREG_W-1:0] issue_vd_i;
  logic                     issue_widen_i;
  logic                     busy_o;
  logic                     unit_req_valid_o;
  logic                     unit_req_ready_i;
  unit_req_t                unit_req_o;
  logic                     unit_rsp_valid_i;
  logic                     unit_rsp_ready_o;
  logic [`VCTRL_ID_W-1:0]   unit_rsp_id_i;
  logic                     unit_rsp_wb_i;
  logic [`VCTRL_RD_W-1:0]   unit_rsp_rd_i;
  logic [`VCTRL_ELEN-1:0]   unit_rsp_data_i;
  logic                     result_valid_o;
  logic                     result_ready_i;
  logic [`VCTRL_RD_W-1:0]   result_rd_o;
  logic [`VCTRL_ELEN-1:0]   result_data_o;

  int errors;
  int seed;

  vctrl_top vctrl_top_i (.*);

  always #4 clk_i = ~clk_i;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp_v);
    if (got !== exp_v) begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp_v);
    end
  endtask

  `include "tb_vctrl_cases.svh"

  initial begin
    clk_i            = 1'b0;
    arst_n_i         = 1'b0;
    issue_valid_i    = 1'b0;
    issue_op_i       = VCFG;
    issue_rd_i       = '0;
    issue_rs1_i      = '0;
    issue_vtype_i    = '{vill: 1'b0, vsew: EW_8, vlmul: LMUL_1};
    issue_csr_mode_i = CSR_READ;
    issue_csr_addr_i = CSR_VSTART;
    issue_vd_i       = '0;
    issue_widen_i    = 1'b0;
    unit_req_ready_i = 1'b0;
    unit_rsp_valid_i = 1'b0;
    unit_rsp_id_i    = '0;
    unit_rsp_wb_i    = 1'b0;
    unit_rsp_rd_i    = '0;
    unit_rsp_data_i  = '0;
    result_ready_i   = 1'b1;
    errors           = 0;
    seed             = 18762;
    repeat (2) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    // Idle state after reset
    @(negedge clk_i);
    compare_value("issue_ready_o", 32'(issue_ready_o), 32'd1);
    compare_value("unit_req_valid_o", 32'(unit_req_valid_o), 32'd0);
    compare_value("result_valid_o", 32'(result_valid_o), 32'd0);
    compare_value("unit_rsp_ready_o", 32'(unit_rsp_ready_o), 32'd1);
    compare_value("busy_o", 32'(busy_o), 32'd0);
    @(posedge clk_i);
    #1;
    build_table();
    run_table();
    run_directed();
    repeat (2) @(posedge clk_i);
    $display("run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/vctrl_consts.svh
/*
 * Vector controller constants
 * Register widths, vector geometry and in-flight instruction count
 */

`ifndef VCTRL_CONSTS_SVH
`define VCTRL_CONSTS_SVH

// Vector geometry
`define VCTRL_VLEN    256
`define VCTRL_ELEN    32
`define VCTRL_VLENB   32

// Instructions in flight and their ID width
`define VCTRL_NR_INSN 4
`define VCTRL_ID_W    2

// vl and vstart reach 256, hence 9 bits
`define VCTRL_VL_W    9

// Register indices
`define VCTRL_VREG_W  5
`define VCTRL_RD_W    5

`endif

// File: verilog/vctrl_csr_file.sv
/*
 * Vector CSR file
 * vstart, vl and vtype with the vsetvl legality check and vlmax
 */

`default_nettype none

`include "vctrl_consts.svh"

module vctrl_csr_file
  import vctrl_pkg::*;
  (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    vctrl_csr_if.csr_side    csr
  );

  localparam int unsigned VlW = `VCTRL_VL_W;
  localparam int unsigned ElenLog = $clog2(`VCTRL_ELEN / 8);
  localparam logic [VlW-1:0] VlenB = `VCTRL_VLENB;

  logic [VlW-1:0]    vstart_q;
  logic [VlW-1:0]    vl_q;
  vtype_t            vtype_q;
  logic              cfg_illegal;
  logic signed [3:0] lmul_s;
  logic signed [3:0] sew_s;
  logic [VlW-1:0]    vlmax;
  logic [VlW-1:0]    vl_next;
  result_word_u      word;

  //////////////////////////////
  // Configuration check
  //////////////////////////////

  // Fractional LMUL reads as a negative power of two
  assign lmul_s = $signed({csr.upd_vtype.vlmul[2], csr.upd_vtype.vlmul});
  assign sew_s  = $signed({1'b0, csr.upd_vtype.vsew});

  // SEW must fit in LMUL * ELEN
  assign cfg_illegal = (csr.upd_vtype.vsew > EW_32) ||
                       (csr.upd_vtype.vlmul inside {LMUL_RES, LMUL_F8}) ||
                       (lmul_s + signed'(4'(ElenLog)) < sew_s);

  always_comb begin
    vlmax = VlenB >> csr.upd_vtype.vsew;
    case (csr.upd_vtype.vlmul)
      LMUL_F2: vlmax = vlmax >> 1;
      LMUL_F4: vlmax = vlmax >> 2;
      LMUL_2:  vlmax = vlmax << 1;
      LMUL_4:  vlmax = vlmax << 2;
      LMUL_8:  vlmax = vlmax << 3;
      default: vlmax = vlmax;
    endcase
  end

  // AVL of all ones asks for vlmax
  always_comb begin
    if (cfg_illegal) begin
      vl_next = '0;
    end else if (csr.upd_rs1 == '1 || csr.upd_rs1 > vlmax) begin
      vl_next = vlmax;
    end else begin
      vl_next = csr.upd_rs1[VlW-1:0];
    end
  end

  //////////////////////////////
  // CSR registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vstart_q <= '0;
      vl_q     <= '0;
      vtype_q  <= '{vill: 1'b1, vsew: EW_8, vlmul: LMUL_1};
    end else if (csr.upd_valid) begin
      if (csr.upd_op == VCFG) begin
        vl_q     <= vl_next;
        vstart_q <= '0;
        if (cfg_illegal) begin
          vtype_q <= '{vill: 1'b1, vsew: EW_8, vlmul: LMUL_1};
        end else begin
          vtype_q <= '{vill: 1'b0, vsew: csr.upd_vtype.vsew, vlmul: csr.upd_vtype.vlmul};
        end
      end else if (csr.upd_op == VCSR && csr.upd_addr == CSR_VSTART) begin
        case (csr.upd_mode)
          CSR_WRITE: vstart_q <= csr.upd_rs1[VlW-1:0];
          CSR_SET:   vstart_q <= vstart_q | csr.upd_rs1[VlW-1:0];
          CSR_CLEAR: vstart_q <= vstart_q & ~csr.upd_rs1[VlW-1:0];
          default:   vstart_q <= vstart_q;
        endcase
      end
    end
  end

  // Read value is the old CSR, or the new vl for a VCFG
  always_comb begin
    word.raw = '0;
    if (csr.upd_op == VCFG) begin
      word.raw = {{(32 - VlW){1'b0}}, vl_next};
    end else begin
      case (csr.upd_addr)
        CSR_VSTART: word.raw = {{(32 - VlW){1'b0}}, vstart_q};
        CSR_VL:     word.raw = {{(32 - VlW){1'b0}}, vl_q};
        CSR_VTYPE: begin
          word.vt.vill  = vtype_q.vill;
          word.vt.vsew  = vtype_q.vsew;
          word.vt.vlmul = vtype_q.vlmul;
        end
        default:    word.raw = 32'(`VCTRL_VLENB);
      endcase
    end
  end

  assign csr.rd_data = word.raw;
  assign csr.vl_next = vl_next;
  assign csr.vl      = vl_q;
  assign csr.vtype   = vtype_q;
  assign csr.vstart  = vstart_q;

  a_vl_max : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    vl_q <= `VCTRL_VLEN);

endmodule

`default_nettype wire

// File: verilog/vctrl_csr_if.sv
/*
 * CSR interface
 * Update commands from the issue stage, CSR state back from the CSR file
 */

`default_nettype none

`include "vctrl_consts.svh"

interface vctrl_csr_if
  import vctrl_pkg::*;
  ();

  // Update command, valid on the pop of a VCFG or VCSR
  logic                   upd_valid;
  op_e                    upd_op;
  csr_mode_e              upd_mode;
  csr_addr_e              upd_addr;
  logic [`VCTRL_ELEN-1:0] upd_rs1;
  vtype_t                 upd_vtype;

  // Current state and read data
  logic [`VCTRL_VL_W-1:0] vl;
  vtype_t                 vtype;
  logic [`VCTRL_VL_W-1:0] vstart;
  logic [`VCTRL_VL_W-1:0] vl_next;
  logic [`VCTRL_ELEN-1:0] rd_data;

  modport csr_side (
    input  upd_valid, upd_op, upd_mode, upd_addr, upd_rs1, upd_vtype,
    output vl, vtype, vstart, vl_next, rd_data
  );

  modport issue_side (
    output upd_valid, upd_op, upd_mode, upd_addr, upd_rs1, upd_vtype,
    input  vl, vtype, vstart, vl_next, rd_data
  );

endinterface

`default_nettype wire

// File: verilog/vctrl_issue.sv
/*
 * Issue stage
 * Request buffer, ID allocation, accept logic and dispatch to the unit
 */

`default_nettype none

`include "vctrl_consts.svh"

module vctrl_issue
  import vctrl_pkg::*;
  (
    input  wire logic                     clk_i,
    input  wire logic                     arst_n_i,
    // Core issue
    input  wire logic                     issue_valid_i,
    output logic                          issue_ready_o,
    output logic                          issue_accept_o,
    input  wire op_e                      issue_op_i,
    input  wire logic [`VCTRL_RD_W-1:0]   issue_rd_i,
    input  wire logic [`VCTRL_ELEN-1:0]   issue_rs1_i,
    input  wire vtype_t                   issue_vtype_i,
    input  wire csr_mode_e                issue_csr_mode_i,
    input  wire csr_addr_e                issue_csr_addr_i,
    input  wire logic [`VCTRL_VREG_W-1:0] issue_vd_i,
    input  wire logic                     issue_widen_i,
    vctrl_csr_if.issue_side               csr,
    // Unit request and completion
    output logic                          unit_req_valid_o,
    input  wire logic                     unit_req_ready_i,
    output unit_req_t                     unit_req_o,
    input  wire logic                     unit_rsp_valid_i,
    input  wire logic [`VCTRL_ID_W-1:0]   unit_rsp_id_i,
    // CSR result
    output logic                          csr_ret_valid_o,
    output logic [`VCTRL_RD_W-1:0]        csr_ret_rd_o,
    output logic [`VCTRL_ELEN-1:0]        csr_ret_data_o,
    input  wire logic                     csr_ret_ready_i,
    output logic                          busy_o
  );

  localparam int unsigned NrInsn = `VCTRL_NR_INSN;
  localparam int unsigned IdW    = `VCTRL_ID_W;

  logic                     buf_valid_q;
  op_e                      buf_op_q;
  logic [`VCTRL_RD_W-1:0]   buf_rd_q;
  logic [`VCTRL_ELEN-1:0]   buf_rs1_q;
  vtype_t                   buf_vtype_q;
  csr_mode_e                buf_mode_q;
  csr_addr_e                buf_addr_q;
  logic [`VCTRL_VREG_W-1:0] buf_vd_q;
  logic                     buf_widen_q;
  logic                     buf_load;
  logic                     buf_pop;
  logic                     req_fire;
  logic [NrInsn-1:0]        running_q;
  logic [IdW-1:0]           next_id;
  logic                     ids_full;

  // Arithmetic needs a legal vtype
  assign issue_accept_o = !(issue_op_i == VARITH && csr.vtype.vill);
  assign issue_ready_o  = !buf_valid_q;
  assign buf_load       = issue_valid_i && issue_ready_o && issue_accept_o;

  //////////////////////////////
  // Request buffer
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      buf_valid_q <= 1'b0;
    end else if (buf_load) begin
      buf_valid_q <= 1'b1;
    end else if (buf_pop) begin
      buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (buf_load) begin
      buf_op_q    <= issue_op_i;
      buf_rd_q    <= issue_rd_i;
      buf_rs1_q   <= issue_rs1_i;
      buf_vtype_q <= issue_vtype_i;
      buf_mode_q  <= issue_csr_mode_i;
      buf_addr_q  <= issue_csr_addr_i;
      buf_vd_q    <= issue_vd_i;
      buf_widen_q <= issue_widen_i;
    end
  end

  //////////////////////////////
  // ID allocation
  //////////////////////////////

  // Lowest free ID wins
  always_comb begin
    next_id = '0;
    for (int i = NrInsn - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        next_id = IdW'(i);
      end
    end
  end

  assign ids_full = &running_q;
  assign busy_o   = |running_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      running_q <= '0;
    end else begin
      if (unit_rsp_valid_i) begin
        running_q[unit_rsp_id_i] <= 1'b0;
      end
      if (req_fire) begin
        running_q[next_id] <= 1'b1;
      end
    end
  end

  // Dispatch
  assign unit_req_valid_o  = buf_valid_q && buf_op_q == VARITH && !ids_full;
  assign req_fire          = unit_req_valid_o && unit_req_ready_i;
  assign unit_req_o.id     = next_id;
  assign unit_req_o.vd     = buf_vd_q;
  assign unit_req_o.vl     = buf_widen_q ? csr.vl << 1 : csr.vl;
  assign unit_req_o.vtype  = csr.vtype;
  assign unit_req_o.vstart = csr.vstart;

  // CSR path retires into the result register
  assign csr_ret_valid_o = buf_valid_q && buf_op_q != VARITH && csr_ret_ready_i;
  assign csr_ret_rd_o    = buf_rd_q;
  assign csr_ret_data_o  = csr.rd_data;
  assign buf_pop         = csr_ret_valid_o || req_fire;

  assign csr.upd_valid = csr_ret_valid_o;
  assign csr.upd_op    = buf_op_q;
  assign csr.upd_mode  = buf_mode_q;
  assign csr.upd_addr  = buf_addr_q;
  assign csr.upd_rs1   = buf_rs1_q;
  assign csr.upd_vtype = buf_vtype_q;

  a_id_free : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    unit_req_valid_o |-> !running_q[unit_req_o.id]);

  a_buf_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    buf_valid_q && !buf_pop |=> buf_valid_q && $stable(buf_rd_q) && $stable(buf_rs1_q));

endmodule

`default_nettype wire

// File: verilog/vctrl_pkg.sv
/*
 * Vector controller package
 * Opcodes, CSR encodings, vtype and the request and result word types
 */

`default_nettype none

`include "vctrl_consts.svh"

package vctrl_pkg;

  // Pre-decoded operation class
  typedef enum logic [1:0] {
    VCFG,
    VCSR,
    VARITH
  } op_e;

  typedef enum logic [1:0] {
    CSR_READ,
    CSR_WRITE,
    CSR_SET,
    CSR_CLEAR
  } csr_mode_e;

  typedef enum logic [1:0] {
    CSR_VSTART,
    CSR_VL,
    CSR_VTYPE,
    CSR_VLENB
  } csr_addr_e;

  // Only EW_8 to EW_32 are legal with ELEN 32
  typedef enum logic [2:0] {
    EW_8  = 3'd0,
    EW_16 = 3'd1,
    EW_32 = 3'd2,
    EW_64 = 3'd3
  } vsew_e;

  typedef enum logic [2:0] {
    LMUL_1   = 3'd0,
    LMUL_2   = 3'd1,
    LMUL_4   = 3'd2,
    LMUL_8   = 3'd3,
    LMUL_RES = 3'd4,
    LMUL_F8  = 3'd5,
    LMUL_F4  = 3'd6,
    LMUL_F2  = 3'd7
  } vlmul_e;

  typedef struct packed {
    logic   vill;
    vsew_e  vsew;
    vlmul_e vlmul;
  } vtype_t;

  // Result word, plain number or vtype layout
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic        vill;
      logic [24:0] rsvd;
      vsew_e       vsew;
      vlmul_e      vlmul;
    } vt;
  } result_word_u;

  typedef struct packed {
    logic [`VCTRL_ID_W-1:0]   id;
    logic [`VCTRL_VREG_W-1:0] vd;
    logic [`VCTRL_VL_W-1:0]   vl;
    vtype_t                   vtype;
    logic [`VCTRL_VL_W-1:0]   vstart;
  } unit_req_t;

endpackage

`default_nettype wire

// File: verilog/vctrl_result.sv
/*
 * Result stage
 * One-entry register toward the core, CSR results ahead of unit write-backs
 */

`default_nettype none

`include "vctrl_consts.svh"

module vctrl_result (
  input  wire logic                   clk_i,
  input  wire logic                   arst_n_i,
  // CSR results from the issue stage
  input  wire logic                   csr_ret_valid_i,
  input  wire logic [`VCTRL_RD_W-1:0] csr_ret_rd_i,
  input  wire logic [`VCTRL_ELEN-1:0] csr_ret_data_i,
  output logic                        csr_ret_ready_o,
  // Scalar write-back from the unit
  input  wire logic                   unit_rsp_valid_i,
  input  wire logic                   unit_rsp_wb_i,
  input  wire logic [`VCTRL_RD_W-1:0] unit_rsp_rd_i,
  input  wire logic [`VCTRL_ELEN-1:0] unit_rsp_data_i,
  output logic                        unit_rsp_ready_o,
  // Core result port
  output logic                        result_valid_o,
  input  wire logic                   result_ready_i,
  output logic [`VCTRL_RD_W-1:0]      result_rd_o,
  output logic [`VCTRL_ELEN-1:0]      result_data_o
);

  logic                   valid_q;
  logic [`VCTRL_RD_W-1:0] rd_q;
  logic [`VCTRL_ELEN-1:0] data_q;
  logic                   slot_free;
  logic                   unit_load;

  // Free when empty or draining this cycle
  assign slot_free        = !valid_q || result_ready_i;
  assign csr_ret_ready_o  = slot_free;
  assign unit_rsp_ready_o = slot_free && !csr_ret_valid_i;
  assign unit_load        = unit_rsp_valid_i && unit_rsp_wb_i && unit_rsp_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (slot_free) begin
      valid_q <= csr_ret_valid_i || unit_load;
    end
  end

  always_ff @(posedge clk_i) begin
    if (csr_ret_valid_i && slot_free) begin
      rd_q   <= csr_ret_rd_i;
      data_q <= csr_ret_data_i;
    end else if (unit_load) begin
      rd_q   <= unit_rsp_rd_i;
      data_q <= unit_rsp_data_i;
    end
  end

  assign result_valid_o = valid_q;
  assign result_rd_o    = rd_q;
  assign result_data_o  = data_q;

  a_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_q && !result_ready_i |=> valid_q && $stable(rd_q) && $stable(data_q));

endmodule

`default_nettype wire

// File: verilog/vctrl_top.sv
/*
 * Vector-unit controller top level
 * Connects the CSR file, the issue stage and the result stage
 */

`default_nettype none

`include "vctrl_consts.svh"

module vctrl_top
  import vctrl_pkg::*;
  (
    input  wire logic                     clk_i,
    input  wire logic                     arst_n_i,
    // Core issue
    input  wire logic                     issue_valid_i,
    output logic                          issue_ready_o,
    output logic                          issue_accept_o,
    input  wire op_e                      issue_op_i,
    input  wire logic [`VCTRL_RD_W-1:0]   issue_rd_i,
    input  wire logic [`VCTRL_ELEN-1:0]   issue_rs1_i,
    input  wire vtype_t                   issue_vtype_i,
    input  wire csr_mode_e                issue_csr_mode_i,
    input  wire csr_addr_e                issue_csr_addr_i,
    input  wire logic [`VCTRL_VREG_W-1:0] issue_vd_i,
    input  wire logic                     issue_widen_i,
    output logic                          busy_o,
    // Vector unit
    output logic                          unit_req_valid_o,
    input  wire logic                     unit_req_ready_i,
    output unit_req_t                     unit_req_o,
    input  wire logic                     unit_rsp_valid_i,
    output logic                          unit_rsp_ready_o,
    input  wire logic [`VCTRL_ID_W-1:0]   unit_rsp_id_i,
    input  wire logic                     unit_rsp_wb_i,
    input  wire logic [`VCTRL_RD_W-1:0]   unit_rsp_rd_i,
    input  wire logic [`VCTRL_ELEN-1:0]   unit_rsp_data_i,
    // Core result
    output logic                          result_valid_o,
    input  wire logic                     result_ready_i,
    output logic [`VCTRL_RD_W-1:0]        result_rd_o,
    output logic [`VCTRL_ELEN-1:0]        result_data_o
  );

  vctrl_csr_if csr_if ();

  logic                   csr_ret_valid;
  logic [`VCTRL_RD_W-1:0] csr_ret_rd;
  logic [`VCTRL_ELEN-1:0] csr_ret_data;
  logic                   csr_ret_ready;
  logic                   unit_rsp_done;

  // A completion retires its ID once any write-back is taken
  assign unit_rsp_done = unit_rsp_valid_i && (!unit_rsp_wb_i || unit_rsp_ready_o);

  vctrl_csr_file vctrl_csr_file_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .csr      (csr_if.csr_side)
  );

  vctrl_issue vctrl_issue_i (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .issue_valid_i    (issue_valid_i),
    .issue_ready_o    (issue_ready_o),
    .issue_accept_o   (issue_accept_o),
    .issue_op_i       (issue_op_i),
    .issue_rd_i       (issue_rd_i),
    .issue_rs1_i      (issue_rs1_i),
    .issue_vtype_i    (issue_vtype_i),
    .issue_csr_mode_i (issue_csr_mode_i),
    .issue_csr_addr_i (issue_csr_addr_i),
    .issue_vd_i       (issue_vd_i),
    .issue_widen_i    (issue_widen_i),
    .csr              (csr_if.issue_side),
    .unit_req_valid_o (unit_req_valid_o),
    .unit_req_ready_i (unit_req_ready_i),
    .unit_req_o       (unit_req_o),
    .unit_rsp_valid_i (unit_rsp_done),
    .unit_rsp_id_i    (unit_rsp_id_i),
    .csr_ret_valid_o  (csr_ret_valid),
    .csr_ret_rd_o     (csr_ret_rd),
    .csr_ret_data_o   (csr_ret_data),
    .csr_ret_ready_i  (csr_ret_ready),
    .busy_o           (busy_o)
  );

  vctrl_result vctrl_result_i (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .csr_ret_valid_i  (csr_ret_valid),
    .csr_ret_rd_i     (csr_ret_rd),
    .csr_ret_data_i   (csr_ret_data),
    .csr_ret_ready_o  (csr_ret_ready),
    .unit_rsp_valid_i (unit_rsp_valid_i),
    .unit_rsp_wb_i    (unit_rsp_wb_i),
    .unit_rsp_rd_i    (unit_rsp_rd_i),
    .unit_rsp_data_i  (unit_rsp_data_i),
    .unit_rsp_ready_o (unit_rsp_ready_o),
    .result_valid_o   (result_valid_o),
    .result_ready_i   (result_ready_i),
    .result_rd_o      (result_rd_o),
    .result_data_o    (result_data_o)
  );

endmodule

`default_nettype wire
